// File: Bender.yml
package:
  name: redund_combiner

sources:
  - rtl/redund_pkg.sv
  - rtl/vote_pkg.sv
  - rtl/copy_bank.sv
  - rtl/vote3_engine.sv
  - rtl/vote5_engine.sv
  - rtl/redund_combiner.sv
  - target: test
    files:
      - verification/redund_combiner_tb.sv

// File: redund_combiner.f
rtl/redund_pkg.sv
rtl/vote_pkg.sv
rtl/copy_bank.sv
rtl/vote3_engine.sv
rtl/vote5_engine.sv
rtl/redund_combiner.sv
verification/redund_combiner_tb.sv

// File: rtl/copy_bank.sv
`timescale 1ns/1ps

module copy_bank
	import redund_pkg::*;
(
	input  logic                   clk,
	input  logic                   we_a,
	input  logic [BANK_ADDR_W-1:0] addr_a,
	input  logic [BYTE_W-1:0]      wr_data_a,
	input  logic [BANK_ADDR_W-1:0] addr_b,
	output logic [BYTE_W-1:0]      rd_data_a,
	output logic [BYTE_W-1:0]      rd_data_b
);

	logic [BYTE_W-1:0] mem [BANK_DEPTH];

	// port a writes and reads, port b only reads
	always_ff @(posedge clk) begin
		if (we_a) begin
			mem[addr_a] <= wr_data_a;
		end
		rd_data_a <= mem[addr_a]; // old data on a write to the same address
		rd_data_b <= mem[addr_b];
	end

endmodule

// File: rtl/redund_combiner.sv
`timescale 1ns/1ps

module redund_combiner
	import redund_pkg::*;
	import vote_pkg::*;
(
	input  logic              clk,
	input  logic              arst_n,
	input  logic [BYTE_W-1:0] rxd,
	input  logic              rxen,
	input  redund_mode_e      redundancy,
	output logic [BYTE_W-1:0] data_out,
	output logic              en_out
);

	logic [BYTE_W-1:0] rxd_q;
	logic              rxen_q;

	logic [NUM_BANKS-1:0]                  bank_we;
	logic [NUM_BANKS-1:0][BANK_ADDR_W-1:0] bank_addr_a;
	logic [NUM_BANKS-1:0][BANK_ADDR_W-1:0] bank_addr_b;
	logic [BYTE_W-1:0]                     bank_wr_data;
	logic [NUM_BANKS-1:0][BYTE_W-1:0]      bank_rd_a;
	logic [NUM_BANKS-1:0][BYTE_W-1:0]      bank_rd_b;

	logic [NUM_BANKS-1:0]                  we3;
	logic [NUM_BANKS-1:0][BANK_ADDR_W-1:0] addr_a3;
	logic [BYTE_W-1:0]                     wr_data3;
	logic [BYTE_W-1:0]                     data_out3;
	logic                                  en_out3;

	logic [NUM_BANKS-1:0]                  we5;
	logic [NUM_BANKS-1:0][BANK_ADDR_W-1:0] addr_a5;
	logic [NUM_BANKS-1:0][BANK_ADDR_W-1:0] addr_b5;
	logic [BYTE_W-1:0]                     wr_data5;
	logic [BYTE_W-1:0]                     data_out5;
	logic                                  en_out5;

	logic [BYTE_W-1:0] sel_data;
	logic              sel_en;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rxen_q <= 1'b0;
		end else begin
			rxen_q <= rxen;
		end
	end

	always_ff @(posedge clk) begin
		rxd_q <= rxd;
	end

	////////////////////
	// shared banks
	////////////////////

	for (genvar k = 0; k < NUM_BANKS; k++) begin : g_bank
		copy_bank copy_bank_inst (
			.clk       (clk),
			.we_a      (bank_we[k]),
			.addr_a    (bank_addr_a[k]),
			.wr_data_a (bank_wr_data),
			.addr_b    (bank_addr_b[k]),
			.rd_data_a (bank_rd_a[k]),
			.rd_data_b (bank_rd_b[k])
		);
	end

	assign bank_addr_b = addr_b5; // only the 5-copy engine reads port b

	// the engine of the selected mode owns the banks
	always_comb begin
		case (redundancy)
			MODE_R3: begin
				bank_we      = we3;
				bank_addr_a  = addr_a3;
				bank_wr_data = wr_data3;
			end
			MODE_R5: begin
				bank_we      = we5;
				bank_addr_a  = addr_a5;
				bank_wr_data = wr_data5;
			end
			default: begin
				bank_we      = '0; // pass-through and unknown modes never write
				bank_addr_a  = addr_a5;
				bank_wr_data = wr_data5;
			end
		endcase
	end

	////////////////////
	// voting engines
	////////////////////

	vote3_engine vote3_engine_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.mode     (redundancy),
		.rxen     (rxen_q),
		.rxd      (rxd_q),
		.rd_a     (bank_rd_a),
		.we       (we3),
		.addr_a   (addr_a3),
		.wr_data  (wr_data3),
		.data_out (data_out3),
		.en_out   (en_out3)
	);

	vote5_engine vote5_engine_inst (
		.clk      (clk),
		.arst_n   (arst_n),
		.mode     (redundancy),
		.rxen     (rxen_q),
		.rxd      (rxd_q),
		.rd_a     (bank_rd_a),
		.rd_b     (bank_rd_b),
		.we       (we5),
		.addr_a   (addr_a5),
		.addr_b   (addr_b5),
		.wr_data  (wr_data5),
		.data_out (data_out5),
		.en_out   (en_out5)
	);

	always_comb begin
		case (redundancy)
			MODE_R1: begin
				sel_data = rxd_q;
				sel_en   = rxen_q;
			end
			MODE_R3: begin
				sel_data = data_out3;
				sel_en   = en_out3;
			end
			MODE_R5: begin
				sel_data = data_out5;
				sel_en   = en_out5;
			end
			default: begin
				sel_data = '0;
				sel_en   = 1'b0;
			end
		endcase
	end

	// output register
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			en_out <= 1'b0;
		end else begin
			en_out <= sel_en;
		end
	end

	always_ff @(posedge clk) begin
		data_out <= sel_data;
	end

endmodule

// File: rtl/redund_pkg.sv
package redund_pkg;

	////////////////////
	// frame store geometry
	////////////////////

	// one received byte
	localparam int BYTE_W = 8;

	// byte index within a frame, frames run from 1 to 256 bytes
	localparam int FRAME_ADDR_W = 8;

	// slot bit on top of the byte index
	localparam int BANK_ADDR_W = FRAME_ADDR_W + 1;

	localparam int NUM_BANKS = 3; // copies 0..2 in slot 0, copies 3..4 in slot 1

	// bytes held by one bank
	localparam int BANK_DEPTH = 2 ** BANK_ADDR_W;

endpackage

// File: rtl/vote3_engine.sv
`timescale 1ns/1ps

module vote3_engine
	import redund_pkg::*;
	import vote_pkg::*;
(
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  redund_mode_e                          mode,
	input  logic                                  rxen,
	input  logic [BYTE_W-1:0]                     rxd,
	input  logic [NUM_BANKS-1:0][BYTE_W-1:0]      rd_a,
	output logic [NUM_BANKS-1:0]                  we,
	output logic [NUM_BANKS-1:0][BANK_ADDR_W-1:0] addr_a,
	output logic [BYTE_W-1:0]                     wr_data,
	output logic [BYTE_W-1:0]                     data_out,
	output logic                                  en_out
);

	vote_state_e             state;
	logic [1:0]              copy_cnt;
	logic [FRAME_ADDR_W-1:0] wr_idx;
	logic [FRAME_ADDR_W-1:0] rd_idx;
	logic [FRAME_ADDR_W-1:0] frame_last; // index of the last byte of copy 0
	logic                    rd_valid;
	logic                    active;
	logic                    wr_byte;
	logic                    reading;

	assign active  = (mode == MODE_R3);
	assign wr_byte = active && rxen && (state != ST_VOTE); // input is dropped while voting
	assign wr_data = rxd;

	// read-back starts in the cycle that ends the last copy
	assign reading = active && ((state == ST_VOTE)
		|| ((state == ST_COLLECT) && !rxen && (copy_cnt == 2'd2)));

	// copy k goes to bank k, slot 0
	always_comb begin
		for (int k = 0; k < NUM_BANKS; k++) begin
			we[k]     = wr_byte && (copy_cnt == k);
			addr_a[k] = {1'b0, reading ? rd_idx : wr_idx};
		end
	end

	////////////////////
	// copy collection and read-back
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ST_IDLE;
			copy_cnt   <= '0;
			wr_idx     <= '0;
			rd_idx     <= '0;
			frame_last <= '0;
		end else if (!active) begin
			state    <= ST_IDLE;
			copy_cnt <= '0;
			wr_idx   <= '0;
			rd_idx   <= '0;
		end else if (reading) begin
			// one read address per cycle up to the last byte of copy 0
			if (rd_idx == frame_last) begin
				state    <= ST_IDLE;
				copy_cnt <= '0;
				wr_idx   <= '0;
				rd_idx   <= '0;
			end else begin
				state  <= ST_VOTE;
				rd_idx <= rd_idx + 1'b1;
			end
		end else begin
			case (state)
				ST_IDLE, ST_GAP: begin
					if (rxen) begin
						wr_idx <= FRAME_ADDR_W'(1); // byte 0 is written this cycle
						state  <= ST_COLLECT;
						if (state == ST_IDLE) begin
							frame_last <= '0;
						end
					end
				end
				ST_COLLECT: begin
					if (rxen) begin
						wr_idx <= wr_idx + 1'b1;
						if (copy_cnt == 2'd0) begin
							frame_last <= wr_idx;
						end
					end else begin
						copy_cnt <= copy_cnt + 1'b1;
						wr_idx   <= '0;
						state    <= ST_GAP;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	// read data arrives one cycle after the address
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_valid <= 1'b0;
			en_out   <= 1'b0;
		end else begin
			rd_valid <= reading;
			en_out   <= rd_valid;
		end
	end

	always_ff @(posedge clk) begin
		data_out <= (rd_a[0] & rd_a[1]) | (rd_a[0] & rd_a[2]) | (rd_a[1] & rd_a[2]);
	end

endmodule

// File: rtl/vote5_engine.sv
`timescale 1ns/1ps

module vote5_engine
	import redund_pkg::*;
	import vote_pkg::*;
(
	input  logic                                  clk,
	input  logic                                  arst_n,
	input  redund_mode_e                          mode,
	input  logic                                  rxen,
	input  logic [BYTE_W-1:0]                     rxd,
	input  logic [NUM_BANKS-1:0][BYTE_W-1:0]      rd_a,
	input  logic [NUM_BANKS-1:0][BYTE_W-1:0]      rd_b,
	output logic [NUM_BANKS-1:0]                  we,
	output logic [NUM_BANKS-1:0][BANK_ADDR_W-1:0] addr_a,
	output logic [NUM_BANKS-1:0][BANK_ADDR_W-1:0] addr_b,
	output logic [BYTE_W-1:0]                     wr_data,
	output logic [BYTE_W-1:0]                     data_out,
	output logic                                  en_out
);

	vote_state_e             state;
	logic [2:0]              copy_cnt;
	logic [1:0]              wr_bank;
	logic                    wr_slot;
	logic [FRAME_ADDR_W-1:0] wr_idx;
	logic [FRAME_ADDR_W-1:0] rd_idx;
	logic [FRAME_ADDR_W-1:0] frame_last;
	logic                    rd_valid;
	logic                    active;
	logic                    wr_byte;
	logic                    reading;

	// bitwise 3-of-5 majority
	function automatic logic [BYTE_W-1:0] maj5(input logic [4:0][BYTE_W-1:0] v);
		logic [2:0]        ones;
		logic [BYTE_W-1:0] m;
		for (int b = 0; b < BYTE_W; b++) begin
			ones = '0;
			for (int c = 0; c < 5; c++) begin
				ones = ones + 3'(v[c][b]);
			end
			m[b] = (ones >= 3'd3);
		end
		return m;
	endfunction

	assign active  = (mode == MODE_R5);
	assign wr_byte = active && rxen && (state != ST_VOTE);
	assign wr_data = rxd;

	// address 0 goes out in the cycle that ends copy 4
	assign reading = active && ((state == ST_VOTE)
		|| ((state == ST_COLLECT) && !rxen && (copy_cnt == 3'd4)));

	// copies 0..2 fill slot 0 of banks 0..2, copies 3 and 4 slot 1 of banks 0 and 1
	always_comb begin
		case (copy_cnt)
			3'd1: wr_bank = 2'd1;
			3'd2: wr_bank = 2'd2;
			3'd4: wr_bank = 2'd1;
			default: wr_bank = 2'd0;
		endcase
		wr_slot = (copy_cnt >= 3'd3);
		for (int k = 0; k < NUM_BANKS; k++) begin
			we[k]     = wr_byte && (wr_bank == k);
			addr_a[k] = reading ? {1'b0, rd_idx} : {wr_slot, wr_idx};
			addr_b[k] = {1'b1, rd_idx}; // slot 1 is only read back through port b
		end
	end

	////////////////////
	// copy collection and read-back
	////////////////////

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state      <= ST_IDLE;
			copy_cnt   <= '0;
			wr_idx     <= '0;
			rd_idx     <= '0;
			frame_last <= '0;
		end else if (!active) begin
			state    <= ST_IDLE;
			copy_cnt <= '0;
			wr_idx   <= '0;
			rd_idx   <= '0;
		end else if (reading) begin
			if (rd_idx == frame_last) begin
				state    <= ST_IDLE;
				copy_cnt <= '0;
				wr_idx   <= '0;
				rd_idx   <= '0;
			end else begin
				state  <= ST_VOTE;
				rd_idx <= rd_idx + 1'b1;
			end
		end else begin
			case (state)
				ST_IDLE, ST_GAP: begin
					if (rxen) begin
						wr_idx <= FRAME_ADDR_W'(1);
						state  <= ST_COLLECT;
						if (state == ST_IDLE) begin
							frame_last <= '0;
						end
					end
				end
				ST_COLLECT: begin
					if (rxen) begin
						wr_idx <= wr_idx + 1'b1;
						if (copy_cnt == 3'd0) begin
							frame_last <= wr_idx; // copy 0 sets the frame length
						end
					end else begin
						copy_cnt <= copy_cnt + 1'b1;
						wr_idx   <= '0;
						state    <= ST_GAP;
					end
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_valid <= 1'b0;
			en_out   <= 1'b0;
		end else begin
			rd_valid <= reading;
			en_out   <= rd_valid;
		end
	end

	always_ff @(posedge clk) begin
		data_out <= maj5({rd_b[1], rd_b[0], rd_a[2], rd_a[1], rd_a[0]});
	end

endmodule

// File: rtl/vote_pkg.sv
package vote_pkg;

	// number of copies sent per frame on the link
	typedef enum logic [7:0] {
		MODE_R1 = 8'd1,
		MODE_R3 = 8'd3,
		MODE_R5 = 8'd5
	} redund_mode_e;

	// shared by the 3-copy and the 5-copy engine
	typedef enum logic [1:0] {
		ST_IDLE,    // waiting for copy 0
		ST_COLLECT, // a copy is being written
		ST_GAP,     // between two copies
		ST_VOTE     // reading back and voting
	} vote_state_e;

endpackage

// File: verification/redund_combiner_tb.sv
`timescale 1ns/1ps

module redund_combiner_tb
	import redund_pkg::*;
	import vote_pkg::*;
();

	localparam int PASS_LAT   = 2;   // input register and output register
	localparam int VOTE_LAT   = 4;   // input reg, bank read, vote reg, output reg
	localparam int WAIT_LIMIT = 600;
	localparam int NUM_TESTS  = 7;

	// one row: mode, length, then two corruptions as copy, byte index and xor mask
	typedef struct packed {
		logic [7:0] mode;
		logic [8:0] len;
		logic [2:0] copy0;
		logic [7:0] idx0;
		logic [7:0] mask0;
		logic [2:0] copy1;
		logic [7:0] idx1;
		logic [7:0] mask1;
	} test_row_t;

	logic              clk;
	logic              arst_n;
	logic [BYTE_W-1:0] rxd;
	logic              rxen;
	logic [7:0]        mode_sig;
	logic [BYTE_W-1:0] data_out;
	logic              en_out;

	test_row_t         tests [NUM_TESTS];
	logic [BYTE_W-1:0] copies [5*256]; // copy c, byte i at c*256+i
	logic [BYTE_W-1:0] exp_frame [256];
	logic [BYTE_W-1:0] out_q [$];
	time               out_t [$];
	logic [31:0]       lfsr;
	int                cyc;
	int                rise_cyc;
	int                rise_cnt;
	logic              en_prev;
	int                pass_cnt;
	int                fail_cnt;

	redund_combiner redund_combiner_inst (
		.clk        (clk),
		.arst_n     (arst_n),
		.rxd        (rxd),
		.rxen       (rxen),
		.redundancy (redund_mode_e'(mode_sig)),
		.data_out   (data_out),
		.en_out     (en_out)
	);

	always #50 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	////////////////////
	// output monitor
	////////////////////

	always @(negedge clk) begin
		if (en_out) begin
			if (!en_prev) begin
				rise_cyc = cyc;
				rise_cnt = rise_cnt + 1;
			end
			out_q.push_back(data_out);
			out_t.push_back($time);
		end
		en_prev = en_out;
	end

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hb4bc_d35c) : (s >> 1);
	endfunction

	task automatic next_byte(output logic [BYTE_W-1:0] b);
		for (int k = 0; k < BYTE_W; k++) begin
			b[k] = lfsr[0];
			lfsr = lfsr_next(lfsr);
		end
	endtask

	function automatic int copies_for(input logic [7:0] mode);
		case (mode)
			8'd1: return 1;
			8'd5: return 5;
			default: return 3;
		endcase
	endfunction

	task automatic build_frame(input test_row_t row, input int r);
		logic [BYTE_W-1:0] b;
		int ones;
		for (int i = 0; i < row.len; i++) begin
			next_byte(b);
			for (int c = 0; c < r; c++) copies[c*256+i] = b;
		end
		if (row.mask0 != 0) copies[int'(row.copy0)*256 + row.idx0] ^= row.mask0;
		if (row.mask1 != 0) copies[int'(row.copy1)*256 + row.idx1] ^= row.mask1;
		for (int i = 0; i < row.len; i++) begin
			for (int k = 0; k < BYTE_W; k++) begin
				ones = 0;
				for (int c = 0; c < r; c++) ones += copies[c*256+i][k];
				exp_frame[i][k] = (2 * ones > r); // set when more than half the copies agree
			end
		end
	endtask

	task automatic send_copies(input int r, input int len, output int first_cyc,
		output int end_cyc);
		for (int c = 0; c < r; c++) begin
			for (int i = 0; i < len; i++) begin
				@(negedge clk);
				if (c == 0 && i == 0) first_cyc = cyc;
				rxen = 1'b1;
				rxd  = copies[c*256+i];
			end
			@(negedge clk);
			rxen    = 1'b0;
			rxd     = '0;
			end_cyc = cyc; // first low cycle after this copy
			@(negedge clk);
		end
	endtask

	task automatic run_test(input int t);
		test_row_t row;
		int r;
		int first_cyc;
		int end_cyc;
		int n;
		int lat;
		int exp_lat;
		bit ok;
		row = tests[t];
		r   = copies_for(row.mode);
		ok  = 1'b1;
		n   = 0;
		@(negedge clk);
		mode_sig = row.mode;
		@(posedge clk);
		out_q.delete();
		out_t.delete();
		rise_cnt = 0;
		build_frame(row, r);
		send_copies(r, row.len, first_cyc, end_cyc);
		if (row.mode == 8'd1 || row.mode == 8'd3 || row.mode == 8'd5) begin
			while ((out_q.size() < row.len || en_prev) && n < WAIT_LIMIT) begin
				@(posedge clk);
				n++;
			end
			assert (n < WAIT_LIMIT) else begin
				$display("test %0d timed out waiting for the end of the output frame", t);
				ok = 1'b0;
			end
			assert (out_q.size() == row.len) else begin
				$display("test %0d output frame has %0d bytes instead of %0d", t,
					out_q.size(), row.len);
				ok = 1'b0;
			end
			assert (rise_cnt == 1) else begin
				$display("test %0d en_out did not come as one unbroken burst", t);
				ok = 1'b0;
			end
			lat     = rise_cyc - ((row.mode == 8'd1) ? first_cyc : end_cyc);
			exp_lat = (row.mode == 8'd1) ? PASS_LAT : VOTE_LAT;
			assert (lat == exp_lat) else begin
				$display("ERR t=%0t en_out latency expected %0d got %0d", $time, exp_lat, lat);
				ok = 1'b0;
			end
			for (int i = 0; i < out_q.size() && i < row.len; i++) begin
				assert (out_q[i] == exp_frame[i]) else begin
					$display("ERR t=%0t data_out[%0d] expected %02h got %02h", out_t[i], i,
						exp_frame[i], out_q[i]);
					ok = 1'b0;
				end
			end
		end else begin
			// no engine owns this mode, the output has to stay quiet
			while (out_q.size() == 0 && n < WAIT_LIMIT) begin
				@(posedge clk);
				n++;
			end
			assert (out_q.size() == 0) else begin
				$display("test %0d en_out went high in unsupported mode %0d", t, row.mode);
				ok = 1'b0;
			end
		end
		if (ok) pass_cnt++;
		else fail_cnt++;
		$display("test %0d mode %0d len %0d: %s", t, row.mode, row.len, ok ? "pass" : "fail");
	endtask

	////////////////////
	// main sequence
	////////////////////

	initial begin
		clk      = 1'b0;
		arst_n   = 1'b0;
		rxd      = '0;
		rxen     = 1'b0;
		mode_sig = 8'd1;
		lfsr     = 32'h41a7;
		cyc      = 0;
		rise_cnt = 0;
		rise_cyc = 0;
		en_prev  = 1'b0;
		pass_cnt = 0;
		fail_cnt = 0;
		tests[0] = {8'd1, 9'd20, 3'd0, 8'd0, 8'h00, 3'd0, 8'd0, 8'h00};
		tests[1] = {8'd3, 9'd64, 3'd0, 8'd0, 8'h00, 3'd0, 8'd0, 8'h00};
		tests[2] = {8'd3, 9'd64, 3'd1, 8'd5, 8'hff, 3'd1, 8'd40, 8'h5a};
		tests[3] = {8'd5, 9'd256, 3'd1, 8'd100, 8'h0f, 3'd3, 8'd100, 8'h3c};
		tests[4] = {8'd3, 9'd32, 3'd0, 8'd7, 8'h81, 3'd2, 8'd7, 8'h81};
		tests[5] = {8'd4, 9'd16, 3'd0, 8'd0, 8'h00, 3'd0, 8'd0, 8'h00};
		tests[6] = {8'd3, 9'd48, 3'd2, 8'd47, 8'hff, 3'd0, 8'd0, 8'h00};
		repeat (8) @(negedge clk);
		arst_n = 1'b1;
		@(negedge clk);
		assert (en_out == 1'b0) else begin
			$display("ERR t=%0t en_out expected 0 got %b", $time, en_out);
			fail_cnt++;
		end
		for (int t = 0; t < NUM_TESTS; t++) run_test(t);
		$display("tests %0d, passed %0d, failed %0d", NUM_TESTS, pass_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule
